/* hdl/lcd_pkg.sv */
// Draw codes, sequencer states, panel commands and glyph addresses; imported by every RTL module
package lcd_pkg;

	typedef enum logic [3:0] {
		START        = 4'd0,
		BARS         = 4'd1,
		TEST         = 4'd7,
		FACE_HAPPY   = 4'd8,
		FACE_NEUTRAL = 4'd9,
		FACE_SAD     = 4'd10,
		FACE_DEAD    = 4'd11,
		STAND_BY     = 4'd12,
		NTEST        = 4'd13
	} draw_code_t;

	typedef enum logic [2:0] {RESET_WAIT, SETUP, FILL, IDLE, TABLE, BARS_RUN} seq_state_t;

	typedef logic [7:0] lcd_byte_t;
	typedef logic [3:0] level_t;

	// ------------------------------------------------------------------------
	localparam lcd_byte_t CMD_SET_X    = 8'h80;
	localparam lcd_byte_t CMD_SET_Y    = 8'h40;
	localparam lcd_byte_t CMD_EXTENDED = 8'h21; // extended set, horizontal addressing
	localparam lcd_byte_t CMD_VOP      = 8'h90; // contrast
	localparam lcd_byte_t CMD_BASIC    = 8'h20;
	localparam lcd_byte_t CMD_NORMAL   = 8'h0C;

	// positions as complete commands
	localparam lcd_byte_t FACE_X        = CMD_SET_X | 8'h25;
	localparam lcd_byte_t FACE_Y_TOP    = CMD_SET_Y | 8'h03;
	localparam lcd_byte_t FACE_Y_BOTTOM = CMD_SET_Y | 8'h04;
	localparam lcd_byte_t MARK_X        = CMD_SET_X | 8'h03;
	localparam lcd_byte_t MARK_Y        = CMD_SET_Y | 8'h02;
	localparam lcd_byte_t HUNGER_X      = CMD_SET_X | 8'h09;
	localparam lcd_byte_t HUNGER_Y      = CMD_SET_Y | 8'h00;
	localparam lcd_byte_t SLEEP_X       = CMD_SET_X | 8'h27;
	localparam lcd_byte_t SLEEP_Y       = CMD_SET_Y | 8'h00;
	localparam lcd_byte_t HEALTH_X      = CMD_SET_X | 8'h42;
	localparam lcd_byte_t HEALTH_Y      = CMD_SET_Y | 8'h00;
	localparam lcd_byte_t FUN_X         = CMD_SET_X | 8'h15;
	localparam lcd_byte_t FUN_Y         = CMD_SET_Y | 8'h01;
	localparam lcd_byte_t MOOD_X        = CMD_SET_X | 8'h3C;
	localparam lcd_byte_t MOOD_Y        = CMD_SET_Y | 8'h01;

	localparam int DISPLAY_BYTES = 504;  // 84 columns x 6 banks
	localparam int BAR_WIDTH     = 13;
	localparam int BAR_MAX       = 4;

	// ------------------------------------------------------------------------
	localparam logic [6:0] GLYPH_SETUP   = 7'd0;
	localparam logic [6:0] GLYPH_HAPPY   = 7'd4;   // 12 records per face
	localparam logic [6:0] GLYPH_NEUTRAL = 7'd16;
	localparam logic [6:0] GLYPH_SAD     = 7'd28;
	localparam logic [6:0] GLYPH_DEAD    = 7'd40;
	localparam logic [6:0] GLYPH_TEST    = 7'd52;
	localparam logic [6:0] GLYPH_NTEST   = 7'd59;

endpackage

/* hdl/lcd_serial_master.sv */
// Write-only serial master for the LCD; times the panel reset, then shifts bytes out MSB first
`timescale 1ns/100ps

module lcd_serial_master import lcd_pkg::*; #(
	parameter int CLK_DIV      = 4,
	parameter int RESET_CYCLES = 16
) (
	input  logic      clock,
	input  logic      arst_n,
	input  logic      send,
	input  lcd_byte_t tx_byte,
	input  logic      tx_dc,
	output logic      accept,
	output logic      mosi,
	output logic      sclk,
	output logic      sce,
	output logic      dc,
	output logic      rst,
	output logic      reset_done
);

	localparam int DIV_W = $clog2(CLK_DIV + 1);
	localparam int RST_W = $clog2(RESET_CYCLES + 1);

	logic [RST_W-1:0] rst_cnt;
	logic             rst_q;
	logic [DIV_W-1:0] div_cnt;
	logic [2:0]       bit_cnt;
	logic             busy;
	logic             sclk_q;
	logic             sce_q;
	logic             dc_q;
	logic             sclk_fall;
	lcd_byte_t        shift_q;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rst_cnt <= '0;
			rst_q   <= 1'b0;
		end else if (!rst_q) begin
			if (rst_cnt == RST_W'(RESET_CYCLES - 1))
				rst_q <= 1'b1;
			else
				rst_cnt <= rst_cnt + 1'b1;
		end
	end

	assign rst        = rst_q;
	assign reset_done = rst_q & ~busy;        // low while a byte is on the line
	assign accept     = send & rst_q & ~busy;
	assign sclk_fall  = busy & sclk_q & (div_cnt == DIV_W'(CLK_DIV - 1));

	// ------------------------------------------------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			busy    <= 1'b0;
			sclk_q  <= 1'b0;
			sce_q   <= 1'b1;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (accept) begin
			busy    <= 1'b1;
			sce_q   <= 1'b0;
			sclk_q  <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (busy) begin
			if (div_cnt == DIV_W'(CLK_DIV - 1)) begin
				div_cnt <= '0;
				sclk_q  <= ~sclk_q;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			if (sclk_fall) begin
				if (bit_cnt == 3'd7) begin
					busy  <= 1'b0;          // byte done, sce high for a clock at least
					sce_q <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			shift_q <= tx_byte;
			dc_q    <= tx_dc;
		end else if (sclk_fall) begin
			shift_q <= {shift_q[6:0], 1'b0};  // next bit on falling sclk
		end
	end

	assign mosi = shift_q[7];
	assign sclk = sclk_q;
	assign sce  = sce_q;
	assign dc   = dc_q;

	// a byte holds the line for 16*CLK_DIV clocks
	assert property (@(posedge clock) disable iff (!arst_n)
		accept |=> !accept [*16*CLK_DIV]);
	assert property (@(posedge clock) disable iff (!arst_n)
		accept |=> !sce [*16*CLK_DIV] ##1 sce);

endmodule

/* hdl/glyph_table.sv */
// Combinational byte records for the setup sequence, the four faces and the test mark
`timescale 1ns/100ps

module glyph_table import lcd_pkg::*; (
	input  logic [6:0] glyph_addr,
	output lcd_byte_t  glyph_byte,
	output logic       glyph_dc,
	output logic       glyph_last
);

	localparam logic [31:0] ROW_HAPPY   = 32'h1214_3452;
	localparam logic [31:0] ROW_NEUTRAL = 32'h1012_3210;
	localparam logic [31:0] ROW_SAD     = 32'h1412_3254;

	logic [6:0]  offset;
	logic [1:0]  face;
	logic [31:0] row;
	lcd_byte_t   top_edge;
	lcd_byte_t   bottom_byte;

	// block decode
	always_comb begin
		face   = 2'd0;
		offset = glyph_addr - GLYPH_SETUP;
		if (glyph_addr >= GLYPH_NTEST)
			offset = glyph_addr - GLYPH_NTEST;
		else if (glyph_addr >= GLYPH_TEST)
			offset = glyph_addr - GLYPH_TEST;
		else if (glyph_addr >= GLYPH_DEAD) begin
			face   = 2'd3;
			offset = glyph_addr - GLYPH_DEAD;
		end else if (glyph_addr >= GLYPH_SAD) begin
			face   = 2'd2;
			offset = glyph_addr - GLYPH_SAD;
		end else if (glyph_addr >= GLYPH_NEUTRAL) begin
			face   = 2'd1;
			offset = glyph_addr - GLYPH_NEUTRAL;
		end else if (glyph_addr >= GLYPH_HAPPY)
			offset = glyph_addr - GLYPH_HAPPY;
	end

	assign row         = (face == 2'd0) ? ROW_HAPPY : (face == 2'd1) ? ROW_NEUTRAL : ROW_SAD;
	assign top_edge    = (face == 2'd3) ? 8'h9E : 8'hDE;  // dead eyes are crossed
	assign bottom_byte = row[31 - 8 * offset[1:0] -: 8];  // offsets 8..11 map to 0..3

	// ------------------------------------------------------------------------
	always_comb begin
		glyph_byte = 8'h00;
		glyph_dc   = 1'b1;
		glyph_last = 1'b0;
		if (glyph_addr < GLYPH_HAPPY) begin
			glyph_dc   = 1'b0;
			glyph_last = (offset == 7'd3);
			case (offset[1:0])
				2'd0:    glyph_byte = CMD_EXTENDED;
				2'd1:    glyph_byte = CMD_VOP;
				2'd2:    glyph_byte = CMD_BASIC;
				default: glyph_byte = CMD_NORMAL;
			endcase
		end else if (glyph_addr < GLYPH_TEST) begin
			glyph_last = (offset == 7'd11);
			case (offset)
				7'd0, 7'd6: begin
					glyph_byte = FACE_X;
					glyph_dc   = 1'b0;
				end
				7'd1: begin
					glyph_byte = FACE_Y_TOP;
					glyph_dc   = 1'b0;
				end
				7'd7: begin
					glyph_byte = FACE_Y_BOTTOM;
					glyph_dc   = 1'b0;
				end
				7'd2, 7'd5: glyph_byte = top_edge;
				7'd3, 7'd4: glyph_byte = 8'h08;
				default:    glyph_byte = bottom_byte;
			endcase
		end else begin
			// test mark and its erase share the position
			glyph_last = (glyph_addr < GLYPH_NTEST) ? (offset == 7'd6) : (offset == 7'd8);
			if (offset == 7'd0) begin
				glyph_byte = MARK_X;
				glyph_dc   = 1'b0;
			end else if (offset == 7'd1) begin
				glyph_byte = MARK_Y;
				glyph_dc   = 1'b0;
			end else if (glyph_addr < GLYPH_NTEST)
				glyph_byte = (offset == 7'd4) ? 8'h7C : 8'h04;
		end
	end

endmodule

/* hdl/level_bars.sv */
// Byte stream for the five level bars; levels are sampled on bars_start, one byte per bars_step
`timescale 1ns/100ps

module level_bars import lcd_pkg::*; (
	input  logic      clock,
	input  logic      arst_n,
	input  logic      bars_start,
	input  logic      bars_step,
	input  level_t    level_hunger,
	input  level_t    level_sleep,
	input  level_t    level_health,
	input  level_t    level_fun,
	input  level_t    level_mood,
	output lcd_byte_t bars_byte,
	output logic      bars_dc,
	output logic      bars_last
);

	localparam logic [3:0] LAST_POS = 4'(BAR_WIDTH + 1);  // x, y, then the columns

	level_t     level_q [5];
	logic [2:0] bar_q;
	logic [3:0] pos_q;
	logic [1:0] phase_q;
	level_t     cur_level;
	lcd_byte_t  cur_x;
	lcd_byte_t  cur_y;
	logic [5:0] col;
	logic [5:0] fill_cols;

	function automatic level_t saturate(level_t l);
		return (l > level_t'(BAR_MAX)) ? level_t'(BAR_MAX) : l;
	endfunction

	always_ff @(posedge clock) begin
		if (bars_start) begin
			level_q[0] <= saturate(level_hunger);
			level_q[1] <= saturate(level_sleep);
			level_q[2] <= saturate(level_health);
			level_q[3] <= saturate(level_fun);
			level_q[4] <= saturate(level_mood);
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			bar_q   <= '0;
			pos_q   <= '0;
			phase_q <= '0;
		end else if (bars_start) begin
			bar_q   <= '0;
			pos_q   <= '0;
			phase_q <= '0;
		end else if (bars_step) begin
			if (pos_q == LAST_POS) begin
				pos_q   <= '0;
				bar_q   <= bar_q + 1'b1;
				phase_q <= '0;
			end else begin
				pos_q <= pos_q + 1'b1;
				if (pos_q >= 4'd2)
					phase_q <= (phase_q == 2'd2) ? 2'd0 : phase_q + 1'b1;  // 7E 7E 00
			end
		end
	end

	always_comb begin
		case (bar_q)
			3'd0:    {cur_x, cur_y, cur_level} = {HUNGER_X, HUNGER_Y, level_q[0]};
			3'd1:    {cur_x, cur_y, cur_level} = {SLEEP_X, SLEEP_Y, level_q[1]};
			3'd2:    {cur_x, cur_y, cur_level} = {HEALTH_X, HEALTH_Y, level_q[2]};
			3'd3:    {cur_x, cur_y, cur_level} = {FUN_X, FUN_Y, level_q[3]};
			default: {cur_x, cur_y, cur_level} = {MOOD_X, MOOD_Y, level_q[4]};
		endcase
	end

	assign col       = {2'b00, pos_q} - 6'd2;
	assign fill_cols = {2'b00, cur_level} + {1'b0, cur_level, 1'b0};  // three columns per unit

	assign bars_dc   = (pos_q >= 4'd2);
	assign bars_byte = (pos_q == 4'd0) ? cur_x :
	                   (pos_q == 4'd1) ? cur_y :
	                   (col < fill_cols && phase_q != 2'd2) ? 8'h7E : 8'h00;
	assign bars_last = (bar_q == 3'd4) && (pos_q == LAST_POS);

endmodule

/* hdl/draw_sequencer.sv */
// Stand-by and dispatch FSM; picks the byte source for the serial master and drives done
`timescale 1ns/100ps

module draw_sequencer import lcd_pkg::*; (
	input  logic       clock,
	input  logic       arst_n,
	input  draw_code_t draw,
	input  logic       accept,
	input  logic       reset_done,
	input  lcd_byte_t  glyph_byte,
	input  logic       glyph_dc,
	input  logic       glyph_last,
	input  lcd_byte_t  bars_byte,
	input  logic       bars_dc,
	input  logic       bars_last,
	output logic       send,
	output lcd_byte_t  tx_byte,
	output logic       tx_dc,
	output logic [6:0] glyph_addr,
	output logic       bars_start,
	output logic       bars_step,
	output logic       done
);

	localparam int FILL_W = $clog2(DISPLAY_BYTES);

	seq_state_t        state;
	draw_code_t        last_code;
	logic [FILL_W-1:0] fill_cnt;
	logic              draining;  // last byte taken, waiting for the line to go idle
	logic              new_req;
	logic              src_last;
	logic [6:0]        table_start;

	always_comb begin
		new_req     = (draw != last_code);
		table_start = GLYPH_SETUP;
		case (draw)
			START, BARS:  table_start = GLYPH_SETUP;
			TEST:         table_start = GLYPH_TEST;
			NTEST:        table_start = GLYPH_NTEST;
			FACE_HAPPY:   table_start = GLYPH_HAPPY;
			FACE_NEUTRAL: table_start = GLYPH_NEUTRAL;
			FACE_SAD:     table_start = GLYPH_SAD;
			FACE_DEAD:    table_start = GLYPH_DEAD;
			default:      new_req = 1'b0;  // stand-by and retired codes
		endcase
	end

	assign bars_start = (state == IDLE) && new_req && (draw == BARS);
	assign bars_step  = accept && (state == BARS_RUN);
	assign done       = (state == IDLE);
	assign send       = !draining &&
	                    (state == SETUP || state == FILL || state == TABLE || state == BARS_RUN);

	// ------------------------------------------------------------------------
	always_comb begin
		tx_byte  = 8'h00;
		tx_dc    = 1'b0;
		src_last = 1'b0;
		case (state)
			SETUP, TABLE: begin
				tx_byte  = glyph_byte;
				tx_dc    = glyph_dc;
				src_last = glyph_last;
			end
			FILL: begin
				tx_dc    = 1'b1;
				src_last = (fill_cnt == FILL_W'(DISPLAY_BYTES - 1));
			end
			BARS_RUN: begin
				tx_byte  = bars_byte;
				tx_dc    = bars_dc;
				src_last = bars_last;
			end
			default: tx_byte = 8'h00;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state      <= RESET_WAIT;
			last_code  <= START;
			glyph_addr <= GLYPH_SETUP;
			fill_cnt   <= '0;
			draining   <= 1'b0;
		end else begin
			case (state)
				RESET_WAIT: if (reset_done) state <= SETUP;
				IDLE: begin
					if (new_req) begin
						last_code  <= draw;
						glyph_addr <= table_start;
						state      <= (draw == START) ? SETUP : (draw == BARS) ? BARS_RUN : TABLE;
					end
				end
				default: begin
					if (draining) begin
						if (reset_done) begin
							state    <= IDLE;
							draining <= 1'b0;
						end
					end else if (accept) begin
						glyph_addr <= glyph_addr + 7'd1;  // both reloaded on dispatch
						fill_cnt   <= fill_cnt + 1'b1;
						if (src_last && state == SETUP) begin
							state    <= FILL;
							fill_cnt <= '0;
						end else if (src_last)
							draining <= 1'b1;
					end
				end
			endcase
		end
	end

	// the master must stay quiet while the panel is in stand-by
	assert property (@(posedge clock) disable iff (!arst_n)
		(state == IDLE) |-> !accept && reset_done);

endmodule

/* hdl/lcd_pet_display.sv */
// Top level of the pet-game LCD driver; joins sequencer, glyph table, bar generator and master
`timescale 1ns/100ps

module lcd_pet_display import lcd_pkg::*; #(
	parameter int CLK_DIV      = 4,   // sclk half-period in clocks
	parameter int RESET_CYCLES = 16
) (
	input  logic       clock,
	input  logic       arst_n,
	input  draw_code_t draw,
	input  level_t     level_hunger,
	input  level_t     level_sleep,
	input  level_t     level_health,
	input  level_t     level_fun,
	input  level_t     level_mood,
	output logic       mosi,
	output logic       sclk,
	output logic       sce,
	output logic       dc,
	output logic       rst,
	output logic       done
);

	logic       send;
	logic       accept;
	logic       reset_done;
	lcd_byte_t  tx_byte;
	logic       tx_dc;
	logic [6:0] glyph_addr;
	lcd_byte_t  glyph_byte;
	logic       glyph_dc;
	logic       glyph_last;
	logic       bars_start;
	logic       bars_step;
	lcd_byte_t  bars_byte;
	logic       bars_dc;
	logic       bars_last;

	draw_sequencer u_seq (.*);

	glyph_table u_glyph (.*);

	level_bars u_bars (.*);

	lcd_serial_master #(.CLK_DIV(CLK_DIV), .RESET_CYCLES(RESET_CYCLES)) u_master (.*);

endmodule

/* test/tb_expected.svh */
// Expected byte lists per draw code and the typed compare tasks; included by the LCD testbench

// one record is {dc, byte}, dc low for a command
function automatic void push_rec(input logic rec_dc, input lcd_byte_t b);
	exp_q.push_back({rec_dc, b});
endfunction

function automatic void expect_setup();
	push_rec(1'b0, 8'h21);
	push_rec(1'b0, 8'h90);
	push_rec(1'b0, 8'h20);
	push_rec(1'b0, 8'h0C);
	for (int i = 0; i < DISPLAY_BYTES; i++)
		push_rec(1'b1, 8'h00);  // whole display RAM cleared
endfunction

function automatic void expect_face(input draw_code_t code);
	lcd_byte_t eye;
	lcd_byte_t bottom [4];
	eye = (code == FACE_DEAD) ? 8'h9E : 8'hDE;
	case (code)
		FACE_HAPPY:   bottom = '{8'h12, 8'h14, 8'h34, 8'h52};
		FACE_NEUTRAL: bottom = '{8'h10, 8'h12, 8'h32, 8'h10};
		default:      bottom = '{8'h14, 8'h12, 8'h32, 8'h54};
	endcase
	push_rec(1'b0, 8'hA5);
	push_rec(1'b0, 8'h43);
	push_rec(1'b1, eye);
	push_rec(1'b1, 8'h08);
	push_rec(1'b1, 8'h08);
	push_rec(1'b1, eye);
	push_rec(1'b0, 8'hA5);
	push_rec(1'b0, 8'h44);
	foreach (bottom[i])
		push_rec(1'b1, bottom[i]);
endfunction

function automatic void expect_mark(input bit erase);
	push_rec(1'b0, 8'h83);
	push_rec(1'b0, 8'h42);
	if (erase) begin
		for (int i = 0; i < 7; i++)
			push_rec(1'b1, 8'h00);
	end else begin
		push_rec(1'b1, 8'h04);
		push_rec(1'b1, 8'h04);
		push_rec(1'b1, 8'h7C);
		push_rec(1'b1, 8'h04);
		push_rec(1'b1, 8'h04);
	end
endfunction

function automatic void expect_bars();
	lcd_byte_t xs [5];
	lcd_byte_t ys [5];
	int        units;
	xs = '{HUNGER_X, SLEEP_X, HEALTH_X, FUN_X, MOOD_X};
	ys = '{HUNGER_Y, SLEEP_Y, HEALTH_Y, FUN_Y, MOOD_Y};
	for (int b = 0; b < 5; b++) begin
		units = (lvl[b] > BAR_MAX) ? BAR_MAX : int'(lvl[b]);
		push_rec(1'b0, xs[b]);
		push_rec(1'b0, ys[b]);
		for (int u = 0; u < units; u++) begin
			push_rec(1'b1, 8'h7E);
			push_rec(1'b1, 8'h7E);
			push_rec(1'b1, 8'h00);
		end
		for (int c = 3 * units; c < BAR_WIDTH; c++)
			push_rec(1'b1, 8'h00);  // padding up to the bar width
	end
endfunction

function automatic void build_expected(input draw_code_t code);
	case (code)
		START:   expect_setup();
		BARS:    expect_bars();
		TEST:    expect_mark(1'b0);
		NTEST:   expect_mark(1'b1);
		FACE_HAPPY, FACE_NEUTRAL, FACE_SAD, FACE_DEAD: expect_face(code);
		default: ;
	endcase
endfunction

// ---------------------------------------------------------------------------
task automatic check_byte(input string name, input lcd_byte_t expected, input lcd_byte_t actual);
	if (actual !== expected) begin
		errors++;
		$display("FAIL %s: expected %02h, actual %02h", name, expected, actual);
	end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
	if (actual !== expected) begin
		errors++;
		$display("FAIL %s: expected %b, actual %b", name, expected, actual);
	end
endtask

task automatic check_count(input string name, input int expected, input int actual);
	if (actual != expected) begin
		errors++;
		$display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
	end
endtask

task automatic check_code(input string name, input draw_code_t expected,
                          input draw_code_t actual);
	if (actual !== expected) begin
		errors++;
		$display("FAIL %s: expected %s, actual %s", name, expected.name(), actual.name());
	end
endtask

/* test/tb_lcd_pet_display.sv */
// Testbench for the pet-game LCD driver; decodes the serial line and checks each picture's bytes
`timescale 1ns/100ps

module tb_lcd_pet_display import lcd_pkg::*; ();

	localparam int TIMEOUT    = 40000;  // clocks, enough for setup plus clear
	localparam int QUIET      = 400;    // clocks with no traffic expected
	localparam int RST_CLOCKS = 16;     // panel reset low time at the default setting

	logic       clock;
	logic       arst_n;
	draw_code_t draw;
	level_t     lvl [5];
	logic       mosi;
	logic       sclk;
	logic       sce;
	logic       dc;
	logic       rst;
	logic       done;

	logic [8:0] exp_q [$];
	logic [8:0] rx_q [$];
	draw_code_t exp_code;
	string      test_name;
	int         errors = 0;
	int         tests = 0;
	int         rx_bits = 0;
	lcd_byte_t  rx_shift;

	`include "tb_expected.svh"

	lcd_pet_display #(.CLK_DIV(2)) uut (
		.clock        (clock),
		.arst_n       (arst_n),
		.draw         (draw),
		.level_hunger (lvl[0]),
		.level_sleep  (lvl[1]),
		.level_health (lvl[2]),
		.level_fun    (lvl[3]),
		.level_mood   (lvl[4]),
		.mosi         (mosi),
		.sclk         (sclk),
		.sce          (sce),
		.dc           (dc),
		.rst          (rst),
		.done         (done)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// ---------------------------------------------------------------------------
	// serial line decoder, MSB first on rising sclk
	always @(posedge sclk) begin
		if (!sce) begin
			rx_shift = {rx_shift[6:0], mosi};
			rx_bits++;
			if (rx_bits == 8) begin
				rx_q.push_back({dc, rx_shift});
				rx_bits = 0;
			end
		end
	end

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR %s", msg);
	endtask

	task automatic compare_stream();
		int errs_before;
		errs_before = errors;
		check_count({test_name, " byte count"}, exp_q.size(), rx_q.size());
		for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
			check_flag($sformatf("%s dc %0d", test_name, i), exp_q[i][8], rx_q[i][8]);
			check_byte($sformatf("%s byte %0d", test_name, i), exp_q[i][7:0], rx_q[i][7:0]);
			if (errors != errs_before)
				break;  // one mismatch is enough per stream
		end
		check_code({test_name, " accepted code"}, exp_code, uut.u_seq.last_code);
		check_flag({test_name, " sce idle"}, 1'b1, sce);
		tests++;
		$display("test %-16s %0d bytes  %s", test_name, rx_q.size(),
		         (errors == errs_before) ? "ok" : "mismatch");
	endtask

	// comparing process, runs at the end of each picture
	always @(posedge done) begin
		compare_stream();
	end

	// ---------------------------------------------------------------------------
	task automatic wait_done_rise();
		int n;
		n = 0;
		while (!done && n < TIMEOUT) begin
			@(negedge clock);
			n++;
		end
		if (!done)
			report_error($sformatf("%s: done did not rise within %0d clocks", test_name, TIMEOUT));
	endtask

	task automatic run_draw(input string name, input draw_code_t code, input bit new_levels);
		int n;
		@(negedge clock);
		if (new_levels)
			foreach (lvl[i])
				lvl[i] = level_t'($urandom % 16);
		exp_q.delete();
		rx_q.delete();
		test_name = name;
		exp_code = code;
		build_expected(code);
		draw = code;
		n = 0;
		do begin
			@(negedge clock);
			n++;
		end while (done && n < 2);
		if (done)
			report_error($sformatf("%s: done did not drop within 2 clocks", name));
		wait_done_rise();
	endtask

	task automatic expect_quiet(input string name, input draw_code_t code);
		int n;
		int errs_before;
		errs_before = errors;
		@(negedge clock);
		rx_q.delete();
		draw = code;
		n = 0;
		while (done && rx_q.size() == 0 && n < QUIET) begin
			@(negedge clock);
			n++;
		end
		check_flag({name, " done"}, 1'b1, done);
		check_count({name, " byte count"}, 0, rx_q.size());
		tests++;
		$display("test %-16s %0d bytes  %s", name, rx_q.size(),
		         (errors == errs_before) ? "ok" : "mismatch");
	endtask

	initial begin
		int n;
		void'($urandom(32'h1fe9));
		arst_n = 1'b0;
		draw = STAND_BY;
		foreach (lvl[i])
			lvl[i] = '0;
		test_name = "start";
		exp_code = START;
		build_expected(START);
		repeat (4) @(negedge clock);
		check_flag("rst during reset", 1'b0, rst);
		check_flag("done during reset", 1'b0, done);
		check_flag("sce during reset", 1'b1, sce);
		check_flag("sclk during reset", 1'b0, sclk);
		arst_n = 1'b1;
		n = 0;
		while (!rst && n < 100) begin
			@(negedge clock);
			n++;
		end
		if (!rst)
			report_error("panel reset was never released");
		else
			check_count("rst low clocks", RST_CLOCKS, n);
		wait_done_rise();

		run_draw("bars_1", BARS, 1'b1);
		run_draw("face_happy", FACE_HAPPY, 1'b0);
		run_draw("face_neutral", FACE_NEUTRAL, 1'b0);
		run_draw("face_sad", FACE_SAD, 1'b0);
		run_draw("face_dead", FACE_DEAD, 1'b0);
		run_draw("bars_2", BARS, 1'b1);
		run_draw("test_mark", TEST, 1'b0);
		run_draw("erase_mark", NTEST, 1'b0);
		expect_quiet("hold_erase", NTEST);
		expect_quiet("stand_by", STAND_BY);
		run_draw("test_mark_again", TEST, 1'b0);  // same code after another one
		run_draw("erase_again", NTEST, 1'b0);
		run_draw("restart", START, 1'b0);

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* lcd_pet_display.f */
+incdir+test
hdl/lcd_pkg.sv
hdl/lcd_serial_master.sv
hdl/glyph_table.sv
hdl/level_bars.sv
hdl/draw_sequencer.sv
hdl/lcd_pet_display.sv
test/tb_lcd_pet_display.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_lcd_pet_display
FILELIST  = lcd_pet_display.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
